/* run.sh */
#!/bin/sh
# Build the compliance testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module compliance_tb -f tb.f

sim_status=0
./obj_dir/Vcompliance_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$sim_status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

/* tb.f */
+incdir+verilog
verilog/compliance_pkg.sv
verilog/mem_bus_if.sv
verilog/bus_xbar.sv
verilog/ram_1p.sv
verilog/riscv_testutil.sv
verilog/compliance_top.sv
verif/compliance_tb.sv

/* verif/compliance_tb.sv */
// ************************************************************
// Directed testbench for the compliance harness: RAM, error
// responder, test-utility registers and signature dump
// ************************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

module compliance_tb;

  localparam int GntTimeout  = 200;
  localparam int RspTimeout  = 8;
  localparam int DumpTimeout = 2000;
  localparam int IdxW        = $clog2(`RAM_SIZE_WORDS);

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 host_req_i;
  logic                 host_we_i;
  logic [`BUS_AW-1:0]   host_addr_i;
  logic [`BUS_DW-1:0]   host_wdata_i;
  logic [`BUS_DW/8-1:0] host_be_i;
  logic                 host_gnt_o;
  logic                 host_rvalid_o;
  logic                 host_err_o;
  logic [`BUS_DW-1:0]   host_rdata_o;
  logic                 sig_valid_o;
  logic                 halt_o;
  logic [`BUS_DW-1:0]   sig_data_o;

  logic [31:0] lcg_state;
  string       test_name;
  // Expected RAM contents by word index
  logic [31:0] ram_model [`RAM_SIZE_WORDS];

  compliance_top dut_i (
    .clk_i         (clk_i        ),
    .rst_n_i       (rst_n_i      ),
    .host_req_i    (host_req_i   ),
    .host_we_i     (host_we_i    ),
    .host_addr_i   (host_addr_i  ),
    .host_wdata_i  (host_wdata_i ),
    .host_be_i     (host_be_i    ),
    .host_gnt_o    (host_gnt_o   ),
    .host_rvalid_o (host_rvalid_o),
    .host_err_o    (host_err_o   ),
    .host_rdata_o  (host_rdata_o ),
    .sig_valid_o   (sig_valid_o  ),
    .halt_o        (halt_o       ),
    .sig_data_o    (sig_data_o   )
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Byte lanes with be set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s %s: expected %08h actual %08h", test_name, what, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s while waiting for %s", test_name, what);
    $display("Regression failed");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_n_i = 1'b0;
    repeat (16) @(negedge clk_i);
    check("gnt in reset", 32'd0, 32'(host_gnt_o));
    check("rvalid in reset", 32'd0, 32'(host_rvalid_o));
    check("err in reset", 32'd0, 32'(host_err_o));
    check("sig_valid in reset", 32'd0, 32'(sig_valid_o));
    check("halt in reset", 32'd0, 32'(halt_o));
    rst_n_i = 1'b1;
  endtask

  // One transfer on the external port
  // Grant is sampled just after the falling edge
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata, output logic err,
                            output int rsp_wait, output logic halt_at_gnt);
    int waited;
    @(negedge clk_i);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    host_be_i    = be;
    waited = 0;
    #1;
    while (!host_gnt_o) begin
      if (waited >= GntTimeout) begin
        report_timeout("external grant");
      end
      @(negedge clk_i);
      #1;
      waited++;
    end
    halt_at_gnt = halt_o;
    @(negedge clk_i);
    host_req_i = 1'b0;
    host_we_i  = 1'b0;
    rsp_wait = 0;
    while (!host_rvalid_o) begin
      if (rsp_wait >= RspTimeout) begin
        report_timeout("external response");
      end
      @(negedge clk_i);
      rsp_wait++;
    end
    rdata = host_rdata_o;
    err   = host_err_o;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    int          rsp_wait;
    logic        halt_at_gnt;
    bus_access(1'b1, addr, data, be, rdata, err, rsp_wait, halt_at_gnt);
    check("write err", 32'd0, 32'(err));
    check("write response latency", 32'd0, 32'(rsp_wait));
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    int   rsp_wait;
    logic halt_at_gnt;
    bus_access(1'b0, addr, 32'd0, 4'hF, data, err, rsp_wait, halt_at_gnt);
    check("read err", 32'd0, 32'(err));
    check("read response latency", 32'd0, 32'(rsp_wait));
  endtask

  task automatic ram_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    bus_write(addr, data, be);
    ram_model[addr[IdxW+1:2]] = merge_bytes(ram_model[addr[IdxW+1:2]], data, be);
  endtask

  task automatic program_dump(input logic [31:0] sig_begin, input logic [31:0] sig_end);
    for (logic [31:0] a = sig_begin; a < sig_end; a += 4) begin
      ram_write(a, lcg_next(), 4'hF);
    end
    bus_write(`TU_BASE + `TU_SIG_BEGIN, sig_begin, 4'hF);
    bus_write(`TU_BASE + `TU_SIG_END, sig_end, 4'hF);
  endtask

  task automatic test_ram_bytes();
    logic [31:0] addr;
    logic [31:0] rdata;
    test_name = "test_ram_bytes";
    for (int i = 0; i < 16; i++) begin
      ram_write(32'h100 + 32'(i) * 4, lcg_next(), 4'hF);
    end
    // Last word of the RAM
    ram_write(32'(`RAM_SIZE_WORDS * 4 - 4), lcg_next(), 4'hF);
    // Every byte-enable pattern once
    for (int i = 0; i < 16; i++) begin
      ram_write(32'h100 + 32'(i) * 4, lcg_next(), 4'(i));
    end
    for (int i = 0; i <= 16; i++) begin
      addr = (i == 16) ? 32'(`RAM_SIZE_WORDS * 4 - 4) : 32'h100 + 32'(i) * 4;
      bus_read(addr, rdata);
      check("ram word", ram_model[addr[IdxW+1:2]], rdata);
    end
  endtask

  task automatic unmapped_probe(input logic [31:0] addr, input logic we);
    logic [31:0] rdata;
    logic        err;
    int          rsp_wait;
    logic        halt_at_gnt;
    bus_access(we, addr, lcg_next(), 4'hF, rdata, err, rsp_wait, halt_at_gnt);
    check("unmapped err", 32'd1, 32'(err));
    check("unmapped rdata", 32'd0, rdata);
    check("unmapped response latency", 32'd0, 32'(rsp_wait));
  endtask

  task automatic test_unmapped();
    test_name = "test_unmapped";
    unmapped_probe(32'h0001_0000, 1'b0);
    unmapped_probe(32'h0003_0000, 1'b1);
    // Just past the test-utility window
    unmapped_probe(32'h0002_0400, 1'b0);
  endtask

  task automatic test_tu_regs();
    logic [31:0] rdata;
    test_name = "test_tu_regs";
    bus_write(`TU_BASE + `TU_SIG_BEGIN, 32'h0000_1000, 4'hF);
    bus_write(`TU_BASE + `TU_SIG_END, 32'h0000_1040, 4'hF);
    bus_read(`TU_BASE + `TU_SIG_BEGIN, rdata);
    check("sig_begin", 32'h0000_1000, rdata);
    bus_read(`TU_BASE + `TU_SIG_END, rdata);
    check("sig_end", 32'h0000_1040, rdata);
    bus_read(`TU_BASE + `TU_HALT, rdata);
    check("halt register", 32'd0, rdata);
    check("halt_o", 32'd0, 32'(halt_o));
    check("sig_valid_o", 32'd0, 32'(sig_valid_o));
  endtask

  task automatic test_signature_dump();
    logic [31:0] sig_begin;
    logic [31:0] sig_end;
    logic [31:0] sig_words [$];
    logic [31:0] addr;
    int          cycles;
    test_name = "test_signature_dump";
    sig_begin = 32'h0000_0400;
    sig_end   = 32'h0000_0440;
    program_dump(sig_begin, sig_end);
    bus_write(`TU_BASE + `TU_HALT, 32'd1, 4'hF);
    cycles = 0;
    while (!halt_o) begin
      if (cycles >= DumpTimeout) begin
        report_timeout("halt after signature dump");
      end
      @(negedge clk_i);
      // Last word arrives in the cycle halt rises
      if (sig_valid_o) begin
        sig_words.push_back(sig_data_o);
      end
      cycles++;
    end
    check("word count", (sig_end - sig_begin) / 4, 32'(sig_words.size()));
    for (int i = 0; i < sig_words.size(); i++) begin
      addr = sig_begin + 32'(i) * 4;
      check("signature word", ram_model[addr[IdxW+1:2]], sig_words[i]);
    end
  endtask

  task automatic test_priority();
    logic [31:0] rdata;
    logic        err;
    int          rsp_wait;
    logic        halt_at_gnt;
    test_name = "test_priority";
    apply_reset();
    program_dump(32'h0000_0800, 32'h0000_0820);
    bus_write(`TU_BASE + `TU_HALT, 32'd1, 4'hF);
    bus_access(1'b0, 32'h0000_0808, 32'd0, 4'hF, rdata, err, rsp_wait, halt_at_gnt);
    check("halt at external grant", 32'd1, 32'(halt_at_gnt));
    check("read err", 32'd0, 32'(err));
    check("read data", ram_model[(32'h0000_0808 >> 2)], rdata);
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_be_i    = '0;
    lcg_state    = 32'd47;
    test_name    = "reset";
    apply_reset();
    test_ram_bytes();
    test_unmapped();
    test_tu_regs();
    test_signature_dump();
    test_priority();
    $display("Regression passed");
    $finish;
  end

endmodule

/* verilog/bus_xbar.sv */
// *********************************************************
// Two-host crossbar: fixed-priority arbiter, address decode,
// response routing and error responder for unmapped addresses
// *********************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

module bus_xbar
  import compliance_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  mem_bus_if.device  host_tu,
  mem_bus_if.device  host_ext,
  mem_bus_if.host    dev_ram,
  mem_bus_if.host    dev_tu
);

  bus_host_e             win_host;
  logic                  win_req;
  logic [`BUS_AW-1:0]    win_addr;
  logic                  win_we;
  logic [`BUS_DW/8-1:0]  win_be;
  logic [`BUS_DW-1:0]    win_wdata;
  logic                  hit_ram;
  logic                  hit_tu;
  bus_device_e           win_dev;
  logic                  win_accept;

  logic                  rsp_valid_q;
  bus_host_e             rsp_host_q;
  bus_device_e           rsp_dev_q;
  logic                  rsp_unmapped_q;
  logic                  rsp_rvalid;
  logic [`BUS_DW-1:0]    rsp_rdata;
  logic                  rsp_err;

  // Test utility always wins
  always_comb begin
    if (host_tu.req) begin
      win_host  = TestUtilHost;
      win_addr  = host_tu.addr;
      win_we    = host_tu.we;
      win_be    = host_tu.be;
      win_wdata = host_tu.wdata;
    end else begin
      win_host  = ExtHost;
      win_addr  = host_ext.addr;
      win_we    = host_ext.we;
      win_be    = host_ext.be;
      win_wdata = host_ext.wdata;
    end
  end

  assign win_req = host_tu.req | host_ext.req;

  // Address decode
  assign hit_ram = (win_addr & `RAM_MASK) == `RAM_BASE;
  assign hit_tu  = (win_addr & `TU_MASK) == `TU_BASE;
  assign win_dev = hit_tu ? TestUtilDevice : Ram;

  assign dev_ram.req   = win_req & hit_ram;
  assign dev_ram.addr  = win_addr;
  assign dev_ram.we    = win_we;
  assign dev_ram.be    = win_be;
  assign dev_ram.wdata = win_wdata;

  assign dev_tu.req    = win_req & hit_tu;
  assign dev_tu.addr   = win_addr;
  assign dev_tu.we     = win_we;
  assign dev_tu.be     = win_be;
  assign dev_tu.wdata  = win_wdata;

  // The error responder takes any unmapped request at once
  always_comb begin
    if (hit_ram) begin
      win_accept = win_req & dev_ram.gnt;
    end else if (hit_tu) begin
      win_accept = win_req & dev_tu.gnt;
    end else begin
      win_accept = win_req;
    end
  end

  assign host_tu.gnt  = win_accept & (win_host == TestUtilHost);
  assign host_ext.gnt = win_accept & (win_host == ExtHost);

  // Route of the one transaction in flight
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q    <= 1'b0;
      rsp_host_q     <= TestUtilHost;
      rsp_dev_q      <= Ram;
      rsp_unmapped_q <= 1'b0;
    end else begin
      rsp_valid_q <= win_accept;
      if (win_accept) begin
        rsp_host_q     <= win_host;
        rsp_dev_q      <= win_dev;
        rsp_unmapped_q <= ~(hit_ram | hit_tu);
      end
    end
  end

  always_comb begin
    if (rsp_unmapped_q) begin
      rsp_rvalid = 1'b1;
      rsp_rdata  = '0;
      rsp_err    = 1'b1;
    end else if (rsp_dev_q == Ram) begin
      rsp_rvalid = dev_ram.rvalid;
      rsp_rdata  = dev_ram.rdata;
      rsp_err    = dev_ram.err;
    end else begin
      rsp_rvalid = dev_tu.rvalid;
      rsp_rdata  = dev_tu.rdata;
      rsp_err    = dev_tu.err;
    end
  end

  assign host_tu.rvalid  = rsp_valid_q & rsp_rvalid & (rsp_host_q == TestUtilHost);
  assign host_tu.rdata   = rsp_rdata;
  assign host_tu.err     = rsp_err;
  assign host_ext.rvalid = rsp_valid_q & rsp_rvalid & (rsp_host_q == ExtHost);
  assign host_ext.rdata  = rsp_rdata;
  assign host_ext.err    = rsp_err;

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_tu.gnt && !host_tu.req) && !(host_ext.gnt && !host_ext.req));

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_tu.gnt && host_ext.gnt));

  // A response only returns to the host granted one cycle earlier
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!host_tu.rvalid || $past(host_tu.gnt)) && (!host_ext.rvalid || $past(host_ext.gnt)));

endmodule

/* verilog/compliance_cfg.svh */
// *********************************************************
// Compliance harness configuration: bus widths, memory map
// and test-utility register offsets
// *********************************************************

`ifndef COMPLIANCE_CFG_SVH
`define COMPLIANCE_CFG_SVH

// Bus widths
`define BUS_AW 32
`define BUS_DW 32

// 64 kB RAM, must stay a power of 2 for the mask below
`define RAM_SIZE_WORDS 16384
`define RAM_BASE       32'h0000_0000
`define RAM_MASK       (~(32'(`RAM_SIZE_WORDS * 4 - 1)))

// Test utility, 1 kB window
`define TU_BASE        32'h0002_0000
`define TU_MASK        (~32'h0000_03FF)

// Register offsets inside the test-utility window
`define TU_SIG_BEGIN   32'h0000_0000
`define TU_SIG_END     32'h0000_0004
`define TU_HALT        32'h0000_0008

`endif

/* verilog/compliance_pkg.sv */
// *********************************************************
// Shared host and device indices for the compliance bus
// *********************************************************

package compliance_pkg;

  // Bus hosts, in decreasing priority
  typedef enum logic {
    TestUtilHost,
    ExtHost
  } bus_host_e;

  // Bus devices behind the crossbar
  // Unmapped addresses go to the error responder, which has no index
  typedef enum logic {
    Ram,
    TestUtilDevice
  } bus_device_e;

endpackage

/* verilog/compliance_top.sv */
// *********************************************************
// Compliance harness top: external host port, crossbar, RAM
// and RISC-V test utility
// *********************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

module compliance_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // External host, stands in for the core data port
  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  logic [`BUS_AW-1:0]    host_addr_i,
  input  logic [`BUS_DW-1:0]    host_wdata_i,
  input  logic [`BUS_DW/8-1:0]  host_be_i,
  output logic                  host_gnt_o,
  output logic                  host_rvalid_o,
  output logic                  host_err_o,
  output logic [`BUS_DW-1:0]    host_rdata_o,

  // Signature stream
  output logic                  sig_valid_o,
  output logic                  halt_o,
  output logic [`BUS_DW-1:0]    sig_data_o
);

  mem_bus_if tu_host_bus ();
  mem_bus_if ext_host_bus ();
  mem_bus_if ram_bus ();
  mem_bus_if tu_dev_bus ();

  assign ext_host_bus.req   = host_req_i;
  assign ext_host_bus.we    = host_we_i;
  assign ext_host_bus.addr  = host_addr_i;
  assign ext_host_bus.wdata = host_wdata_i;
  assign ext_host_bus.be    = host_be_i;

  assign host_gnt_o    = ext_host_bus.gnt;
  assign host_rvalid_o = ext_host_bus.rvalid;
  assign host_err_o    = ext_host_bus.err;
  assign host_rdata_o  = ext_host_bus.rdata;

  bus_xbar u_xbar (
    .clk_i    (clk_i       ),
    .rst_n_i  (rst_n_i     ),
    .host_tu  (tu_host_bus ),
    .host_ext (ext_host_bus),
    .dev_ram  (ram_bus     ),
    .dev_tu   (tu_dev_bus  )
  );

  // Shared instruction and data memory
  ram_1p #(
    .Depth (`RAM_SIZE_WORDS)
  ) u_ram (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .bus     (ram_bus)
  );

  riscv_testutil u_riscv_testutil (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .dev         (tu_dev_bus ),
    .host        (tu_host_bus),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o ),
    .halt_o      (halt_o     )
  );

endmodule

/* verilog/mem_bus_if.sv */
// *********************************************************
// One req/gnt/rvalid memory bus between a host and a device
// *********************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

interface mem_bus_if;

  // Request, driven by the host
  logic                  req;
  logic [`BUS_AW-1:0]    addr;
  logic                  we;
  logic [`BUS_DW/8-1:0]  be;
  logic [`BUS_DW-1:0]    wdata;

  // Response, driven by the device
  logic                  gnt;
  logic                  rvalid;
  logic [`BUS_DW-1:0]    rdata;
  logic                  err;

  modport host (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport device (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

/* verilog/ram_1p.sv */
// *********************************************************
// Single-port word RAM with byte enables, one-cycle response
// *********************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

module ram_1p #(
  parameter int unsigned Depth = `RAM_SIZE_WORDS
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  mem_bus_if.device  bus
);

  localparam int unsigned IdxW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [`BUS_DW-1:0] mem [Depth];
  logic [IdxW-1:0]    idx;
  logic [`BUS_DW-1:0] rdata_q;
  logic               rvalid_q;

  // Word index, byte offset dropped
  assign idx = bus.addr[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int i = 0; i < `BUS_DW / 8; i++) begin
          if (bus.be[i]) begin
            mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end
      // Writes return the old word
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  // Always ready
  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.req |-> ((bus.addr >> 2) < Depth));

endmodule

/* verilog/riscv_testutil.sv */
// *********************************************************
// Test utility: signature range and halt registers, plus a
// host engine that reads the signature out over the bus
// *********************************************************

`timescale 1ns/1ps

`include "compliance_cfg.svh"

module riscv_testutil (
  input  logic               clk_i,
  input  logic               rst_n_i,
  mem_bus_if.device          dev,
  mem_bus_if.host            host,
  output logic               sig_valid_o,
  output logic [`BUS_DW-1:0] sig_data_o,
  output logic               halt_o
);

  logic [`BUS_AW-1:0] sig_begin_q;
  logic [`BUS_AW-1:0] sig_end_q;
  logic [`BUS_AW-1:0] dev_off;
  logic [`BUS_DW-1:0] be_mask;
  logic               dev_wr;
  logic               dev_rvalid_q;
  logic [`BUS_DW-1:0] dev_rdata_q;
  logic               dump_start;
  logic               dump_busy_q;
  logic [`BUS_AW-1:0] rd_addr_q;
  logic [`BUS_AW-1:0] rd_addr_next;
  logic               halt_q;

  assign dev_off = dev.addr & ~`TU_MASK;
  assign dev_wr  = dev.req & dev.we;

  always_comb begin
    for (int i = 0; i < `BUS_DW / 8; i++) begin
      be_mask[8*i +: 8] = {8{dev.be[i]}};
    end
  end

  // Signature range registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sig_begin_q <= '0;
      sig_end_q   <= '0;
    end else if (dev_wr) begin
      if (dev_off == `TU_SIG_BEGIN) begin
        sig_begin_q <= (sig_begin_q & ~be_mask) | (dev.wdata & be_mask);
      end
      if (dev_off == `TU_SIG_END) begin
        sig_end_q <= (sig_end_q & ~be_mask) | (dev.wdata & be_mask);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev.req) begin
      case (dev_off)
        `TU_SIG_BEGIN: dev_rdata_q <= sig_begin_q;
        `TU_SIG_END:   dev_rdata_q <= sig_end_q;
        `TU_HALT:      dev_rdata_q <= {{(`BUS_DW-1){1'b0}}, halt_q};
        default:       dev_rdata_q <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dev_rvalid_q <= 1'b0;
    end else begin
      dev_rvalid_q <= dev.req;
    end
  end

  assign dev.gnt    = dev.req;
  assign dev.rvalid = dev_rvalid_q;
  assign dev.rdata  = dev_rdata_q;
  assign dev.err    = 1'b0;

  // Dump engine
  // Halt writes during or after a dump are dropped
  assign dump_start   = dev_wr & (dev_off == `TU_HALT) & ~dump_busy_q & ~halt_q;
  assign rd_addr_next = rd_addr_q + `BUS_AW'(4);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dump_busy_q <= 1'b0;
      halt_q      <= 1'b0;
      rd_addr_q   <= '0;
    end else if (dump_start) begin
      if (sig_end_q > sig_begin_q) begin
        dump_busy_q <= 1'b1;
        rd_addr_q   <= sig_begin_q;
      end else begin
        halt_q <= 1'b1;
      end
    end else if (host.gnt) begin
      rd_addr_q <= rd_addr_next;
      // Halt rises together with the last signature word
      if (rd_addr_next >= sig_end_q) begin
        dump_busy_q <= 1'b0;
        halt_q      <= 1'b1;
      end
    end
  end

  // Next read goes out in the same cycle as the previous response
  assign host.req   = dump_busy_q;
  assign host.addr  = rd_addr_q;
  assign host.we    = 1'b0;
  assign host.be    = '1;
  assign host.wdata = '0;

  assign sig_valid_o = host.rvalid;
  assign sig_data_o  = host.rdata;
  assign halt_o      = halt_q;

  a_sig_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dump_start |-> (sig_end_q >= sig_begin_q));

endmodule
